// ==== build.f ====
design/ahbl_pkg.sv
design/bitmap_mux.sv
design/ahbl_splitter.sv
design/ahbl_sram.sv
design/ahbl_regs.sv
design/ahbl_subsys_top.sv
dv/tb_clock_gen.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the AHB-lite subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_top -Mdir obj_dir -o tb_sim -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "Run passed"
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== dv/tb_top.sv ====
// Testbench for the AHB-lite subsystem.
// Issues random pipelined transfers to the SRAM and the register block and
// checks every data phase against a reference model of both slaves.

`timescale 1ns/1ps

module tb_top;

localparam logic [31:0] SRAM_BASE = 32'h2000_0000;
localparam logic [31:0] REGS_BASE = 32'h4000_0000;
localparam int          SRAM_WORDS = 256;
localparam logic [31:0] SEED = 32'h9425c0d4;

// One queued bus item
// Idle marks a cycle with HTRANS IDLE
typedef struct packed {
	logic             idle;
	logic             write;
	ahbl_pkg::hsize_t size;
	logic [31:0]      addr;
	logic [31:0]      wdata;
} xfer_t;

// Observed end of one data phase
typedef struct packed {
	xfer_t       x;
	logic [31:0] rdata;
	logic        resp;
	logic        wait_resp;
	logic [3:0]  waits;
} done_t;

logic              clk;
logic              rst_n;
logic              hready_resp;
logic              hresp;
logic [31:0]       hrdata;
logic [31:0]       haddr;
logic              hwrite;
ahbl_pkg::htrans_t htrans;
ahbl_pkg::hsize_t  hsize;
ahbl_pkg::hburst_t hburst;
ahbl_pkg::hprot_t  hprot;
logic              hmastlock;
logic [31:0]       hwdata;

xfer_t       issue_q[$];
done_t       done_q[$];
xfer_t       dph;
logic        dph_open;
logic [3:0]  dph_waits;
logic        dph_wait_resp;
// Reference state of both slaves
// Index 0 of the scratch array stays unused
logic [31:0] ref_sram [SRAM_WORDS];
logic [31:0] ref_scratch [4];
int          n_issued = 0;
int          n_checked = 0;
int          cycle_cnt = 0;
int          cycle_limit = 0;

tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) clock_i (.clk(clk), .rst_n(rst_n));

// Single master so hready loops straight back
ahbl_subsys_top #(.SRAM_DEPTH(SRAM_WORDS)) dut_i (
	.clk(clk), .rst_n(rst_n),
	.hready(hready_resp), .hready_resp(hready_resp), .hresp(hresp),
	.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
	.hburst(hburst), .hprot(hprot), .hmastlock(hmastlock),
	.hwdata(hwdata), .hrdata(hrdata)
);

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("[ERROR] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
		$display("TB FAILED");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

// Expected read data, response and wait cycles of one transfer
// Writes update the model as a side effect
function automatic logic [31:0] ref_access(input xfer_t x, output logic resp,
		output logic [3:0] waits);
	logic [31:0] rdata;
	logic [1:0]  off;
	int          idx;
	rdata = '0;
	resp = ahbl_pkg::HRESP_OKAY;
	waits = 4'd0;
	off = x.addr[3:2];
	idx = int'((x.addr >> 2) % SRAM_WORDS);
	if (x.addr[31:28] == SRAM_BASE[31:28]) begin
		// A byte lane is written when it lies inside the aligned transfer
		for (int b = 0; b < 4; b++) begin
			if (x.write && ((b >> x.size) == (x.addr[1:0] >> x.size))) begin
				ref_sram[idx][b*8 +: 8] = x.wdata[b*8 +: 8];
			end
		end
		rdata = ref_sram[idx];
	end else begin
		// Every register access has one wait cycle
		waits = 4'd1;
		if (x.write && off == ahbl_pkg::REGS_ID_OFFSET) begin
			resp = ahbl_pkg::HRESP_ERROR;
		end else if (x.write) begin
			ref_scratch[off] = x.wdata;
		end else if (off == ahbl_pkg::REGS_ID_OFFSET) begin
			rdata = ahbl_pkg::REGS_ID_VALUE;
		end else begin
			rdata = ref_scratch[off];
		end
	end
	return rdata;
endfunction

task automatic push_transfer(input logic write, input ahbl_pkg::hsize_t size,
		input logic [31:0] addr, input logic [31:0] wdata);
	issue_q.push_back({1'b0, write, size, addr, wdata});
	n_issued++;
endtask

task automatic add_idle_cycle();
	issue_q.push_back({1'b1, 1'b0, ahbl_pkg::HSIZE_WORD, 32'd0, 32'd0});
endtask

// Random word address anywhere in the SRAM window
// The word index wraps modulo the depth
function automatic logic [31:0] random_sram_addr();
	return SRAM_BASE | ($urandom & 32'h0fff_fffc);
endfunction

// Present the next address phase and current write data on the falling edge,
// then wait for a rising edge with hready_resp high
task automatic bus_step(input xfer_t nxt);
	logic  accepted;
	done_t d;
	accepted = 1'b0;
	@(negedge clk);
	haddr = nxt.addr;
	hwrite = nxt.write;
	hsize = nxt.size;
	htrans = nxt.idle ? ahbl_pkg::HTRANS_IDLE : ahbl_pkg::HTRANS_NONSEQ;
	hwdata = (dph_open && dph.write) ? dph.wdata : 32'd0;
	while (!accepted) begin
		@(posedge clk);
		// Nothing in flight so the splitter answers by itself
		if (!dph_open) begin
			check_value(32'(hready_resp), 32'd1, "hready_resp with no data phase");
			check_value(32'(hresp), 32'(ahbl_pkg::HRESP_OKAY), "hresp with no data phase");
		end
		if (hready_resp === 1'b1) begin
			accepted = 1'b1;
		end else begin
			dph_waits = dph_waits + 4'd1;
			dph_wait_resp = hresp;
		end
	end
	if (dph_open) begin
		d = {dph, hrdata, hresp, dph_wait_resp, dph_waits};
		done_q.push_back(d);
	end
	// Accepted address phase becomes the data phase
	dph = nxt;
	dph_open = !nxt.idle;
	dph_waits = 4'd0;
	dph_wait_resp = 1'b0;
endtask

// Completed data phases checked in issue order
always @(negedge clk) begin : compare
	done_t       d;
	logic [31:0] exp_rdata;
	logic        exp_resp;
	logic [3:0]  exp_waits;
	while (done_q.size() > 0) begin
		d = done_q.pop_front();
		exp_rdata = ref_access(d.x, exp_resp, exp_waits);
		check_value(32'(d.waits), 32'(exp_waits), $sformatf("wait cycles at %08h", d.x.addr));
		check_value(32'(d.resp), 32'(exp_resp), $sformatf("hresp at %08h", d.x.addr));
		// ERROR must already show in the stalled cycle
		if (d.waits != 4'd0) begin
			check_value(32'(d.wait_resp), 32'(exp_resp), "hresp in wait cycle");
		end
		if (!d.x.write) begin
			check_value(d.rdata, exp_rdata, $sformatf("hrdata at %08h", d.x.addr));
		end
		n_checked++;
	end
end

always @(posedge clk) begin : watchdog
	cycle_cnt = cycle_cnt + 1;
	if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
		$display("Timeout: bus traffic did not finish within %0d cycles", cycle_limit);
		$display("TB FAILED");
		$fatal(1, "run aborted after timeout");
	end
end

initial begin : stimulus
	logic [31:0] addrs [16];
	logic [31:0] a;
	htrans = ahbl_pkg::HTRANS_IDLE;
	haddr = 32'd0;
	hwrite = 1'b0;
	hsize = ahbl_pkg::HSIZE_WORD;
	hburst = 3'b000;
	hprot = 4'b0011;
	hmastlock = 1'b0;
	hwdata = 32'd0;
	dph = '0;
	dph_open = 1'b0;
	dph_waits = 4'd0;
	dph_wait_resp = 1'b0;
	for (int i = 0; i < 4; i++) begin
		ref_scratch[i] = 32'd0;
	end
	void'($urandom(SEED));
	// Idle straight after reset
	add_idle_cycle();
	add_idle_cycle();
	// Word writes with idle gaps and their read back
	for (int i = 0; i < 16; i++) begin
		addrs[i] = random_sram_addr();
		push_transfer(1'b1, ahbl_pkg::HSIZE_WORD, addrs[i], $urandom);
		if ($urandom_range(3) == 0) begin
			add_idle_cycle();
		end
	end
	for (int i = 0; i < 16; i++) begin
		push_transfer(1'b0, ahbl_pkg::HSIZE_WORD, addrs[i], 32'd0);
	end
	// Byte and halfword lanes merged into a known word
	for (int i = 0; i < 8; i++) begin
		a = random_sram_addr();
		push_transfer(1'b1, ahbl_pkg::HSIZE_WORD, a, $urandom);
		push_transfer(1'b1, ahbl_pkg::HSIZE_BYTE, a | ($urandom & 32'h3), $urandom);
		push_transfer(1'b1, ahbl_pkg::HSIZE_HALF, a | ($urandom & 32'h2), $urandom);
		push_transfer(1'b0, ahbl_pkg::HSIZE_WORD, a, 32'd0);
	end
	// Scratch register writes then reads of all four offsets
	for (int i = 1; i < 4; i++) begin
		push_transfer(1'b1, ahbl_pkg::HSIZE_WORD, REGS_BASE + 32'(4 * i), $urandom);
	end
	for (int i = 0; i < 4; i++) begin
		push_transfer(1'b0, ahbl_pkg::HSIZE_WORD, REGS_BASE + 32'(4 * i), 32'd0);
	end
	// Refused ID write followed by an ID read
	push_transfer(1'b1, ahbl_pkg::HSIZE_WORD, REGS_BASE, $urandom);
	push_transfer(1'b0, ahbl_pkg::HSIZE_WORD, REGS_BASE, 32'd0);
	// Back-to-back transfers alternating between slaves
	for (int i = 0; i < 24; i++) begin
		a = i[0] ? (REGS_BASE | ($urandom & 32'hc)) : addrs[4'($urandom_range(15))];
		push_transfer(1'($urandom_range(1)), ahbl_pkg::HSIZE_WORD, a, $urandom);
	end
	add_idle_cycle();
	add_idle_cycle();
	cycle_limit = 4 * n_issued + 50;
	@(posedge rst_n);
	while (issue_q.size() > 0) begin
		bus_step(issue_q.pop_front());
	end
	while (dph_open) begin
		add_idle_cycle();
		bus_step(issue_q.pop_front());
	end
	// Let the compare process catch up
	repeat (2) @(negedge clk);
	if (n_checked == n_issued) begin
		$display("TB PASSED");
		$finish;
	end else begin
		$display("Only %0d of %0d transfers were checked", n_checked, n_issued);
		$display("TB FAILED");
		$fatal(1, "transfers missing at the end of the run");
	end
end

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source.
// Free-running clock and an active-low reset held for RESET_CYCLES rising edges.

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

initial begin
	clk = 1'b0;
	forever #(PERIOD_NS / 2) clk = ~clk;
end

// Release on a falling edge, clear of the flops
initial begin
	rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
end

endmodule

// ==== design/ahbl_subsys_top.sv ====
// AHB-lite subsystem with one master port, a 1:2 splitter, an SRAM and a
// register block. Port 0 maps the SRAM at 0x2000_0000 and port 1 maps the
// registers at 0x4000_0000. Tie hready to hready_resp outside.

`timescale 1ns/1ps

module ahbl_subsys_top #(
	parameter int N_PORTS = 2,
	parameter int W_ADDR = 32,
	parameter int W_DATA = 32,
	parameter logic [N_PORTS*W_ADDR-1:0] ADDR_MAP = {32'h4000_0000, 32'h2000_0000},
	parameter logic [N_PORTS*W_ADDR-1:0] ADDR_MASK = {32'hf000_0000, 32'hf000_0000},
	parameter int SRAM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              hready,
	output logic              hready_resp,
	output logic              hresp,
	input  logic [W_ADDR-1:0] haddr,
	input  logic              hwrite,
	input  ahbl_pkg::htrans_t htrans,
	input  ahbl_pkg::hsize_t  hsize,
	input  ahbl_pkg::hburst_t hburst,
	input  ahbl_pkg::hprot_t  hprot,
	input  logic              hmastlock,
	input  logic [W_DATA-1:0] hwdata,
	output logic [W_DATA-1:0] hrdata
);

// Per-port slave buses
logic [N_PORTS-1:0]              s_hready;
logic [N_PORTS-1:0]              s_hready_resp;
logic [N_PORTS-1:0]              s_hresp;
logic [N_PORTS-1:0][W_ADDR-1:0]  s_haddr;
logic [N_PORTS-1:0]              s_hwrite;
ahbl_pkg::htrans_t [N_PORTS-1:0] s_htrans;
ahbl_pkg::hsize_t [N_PORTS-1:0]  s_hsize;
logic [N_PORTS-1:0][W_DATA-1:0]  s_hwdata;
logic [N_PORTS-1:0][W_DATA-1:0]  s_hrdata;

// Burst, protection and lock stop at the splitter
// Neither slave acts on them
ahbl_splitter #(
	.N_PORTS(N_PORTS),
	.W_ADDR(W_ADDR),
	.W_DATA(W_DATA),
	.ADDR_MAP(ADDR_MAP),
	.ADDR_MASK(ADDR_MASK)
) splitter_i (
	.clk(clk), .rst_n(rst_n),
	.hready(hready), .hready_resp(hready_resp), .hresp(hresp),
	.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
	.hburst(hburst), .hprot(hprot), .hmastlock(hmastlock),
	.hwdata(hwdata), .hrdata(hrdata),
	.m_hready(s_hready), .m_hready_resp(s_hready_resp), .m_hresp(s_hresp),
	.m_haddr(s_haddr), .m_hwrite(s_hwrite), .m_htrans(s_htrans), .m_hsize(s_hsize),
	.m_hburst(), .m_hprot(), .m_hmastlock(),
	.m_hwdata(s_hwdata), .m_hrdata(s_hrdata)
);

// Port 0 is the zero-wait SRAM
ahbl_sram #(.W_ADDR(W_ADDR), .W_DATA(W_DATA), .SRAM_DEPTH(SRAM_DEPTH)) sram_i (
	.clk(clk), .rst_n(rst_n),
	.hready(s_hready[0]), .htrans(s_htrans[0]), .haddr(s_haddr[0]),
	.hwrite(s_hwrite[0]), .hsize(s_hsize[0]), .hwdata(s_hwdata[0]),
	.hready_resp(s_hready_resp[0]), .hresp(s_hresp[0]), .hrdata(s_hrdata[0])
);

// Port 1 is the one-wait register block
ahbl_regs #(.W_ADDR(W_ADDR), .W_DATA(W_DATA)) regs_i (
	.clk(clk), .rst_n(rst_n),
	.hready(s_hready[1]), .htrans(s_htrans[1]), .haddr(s_haddr[1]),
	.hwrite(s_hwrite[1]), .hsize(s_hsize[1]), .hwdata(s_hwdata[1]),
	.hready_resp(s_hready_resp[1]), .hresp(s_hresp[1]), .hrdata(s_hrdata[1])
);

endmodule

// ==== design/ahbl_regs.sv ====
// AHB-lite register slave with one wait state on every access.
// Offset 0 is a read-only ID register and offsets 1 to 3 are scratch registers.
// A write to the ID offset gets the two-cycle ERROR response.

`timescale 1ns/1ps

module ahbl_regs #(
	parameter int W_ADDR = 32,
	parameter int W_DATA = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              hready,
	input  ahbl_pkg::htrans_t htrans,
	input  logic [W_ADDR-1:0] haddr,
	input  logic              hwrite,
	// Size is ignored, every register is written as a full word
	input  ahbl_pkg::hsize_t  hsize,
	input  logic [W_DATA-1:0] hwdata,
	output logic              hready_resp,
	output logic              hresp,
	output logic [W_DATA-1:0] hrdata
);

typedef enum logic [1:0] {
	ST_IDLE,
	ST_WAIT,
	ST_ERR1,
	ST_ERR2
} state_t;

state_t                 state;
state_t                 state_nxt;
logic                   aph_take;
logic                   aph_id_write;
logic                   dph_write;
ahbl_pkg::regs_offset_t dph_offset;
logic [W_DATA-1:0]      scratch [ahbl_pkg::REGS_N_SCRATCH];
logic [W_DATA-1:0]      rdata_q;

assign aph_take = hready && htrans == ahbl_pkg::HTRANS_NONSEQ;
assign aph_id_write = hwrite && haddr[3:2] == ahbl_pkg::REGS_ID_OFFSET;

always_comb begin
	state_nxt = state;
	case (state)
		// Wait cycle always leads to the ready cycle
		ST_WAIT: state_nxt = ST_IDLE;
		ST_ERR1: state_nxt = ST_ERR2;
		// Idle and second ERROR cycle have hready high
		// A new address phase may start here
		default: begin
			if (aph_take) begin
				state_nxt = aph_id_write ? ST_ERR1 : ST_WAIT;
			end else begin
				state_nxt = ST_IDLE;
			end
		end
	endcase
end

// FSM, write flag and scratch registers
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= ST_IDLE;
		dph_write <= 1'b0;
		for (int i = 0; i < ahbl_pkg::REGS_N_SCRATCH; i++) begin
			scratch[i] <= '0;
		end
	end else begin
		state <= state_nxt;
		if (aph_take) begin
			dph_write <= hwrite;
		end
		// Scratch write at the end of the wait cycle
		// ID writes never reach ST_WAIT
		if (state == ST_WAIT && dph_write) begin
			scratch[dph_offset - 2'd1] <= hwdata;
		end
	end
end

// Captured offset and read data
always_ff @(posedge clk) begin
	if (aph_take) begin
		dph_offset <= haddr[3:2];
	end
	if (state == ST_WAIT && !dph_write) begin
		if (dph_offset == ahbl_pkg::REGS_ID_OFFSET) begin
			rdata_q <= W_DATA'(ahbl_pkg::REGS_ID_VALUE);
		end else begin
			rdata_q <= scratch[dph_offset - 2'd1];
		end
	end
end

// Low in the wait cycle and the first ERROR cycle
assign hready_resp = !(state == ST_WAIT || state == ST_ERR1);
assign hresp = (state == ST_ERR1 || state == ST_ERR2) ?
	ahbl_pkg::HRESP_ERROR : ahbl_pkg::HRESP_OKAY;
assign hrdata = rdata_q;

// ERROR with ready high only as the second cycle of the pair
err_two_cycle: assert property (
	@(posedge clk) disable iff (!rst_n)
	(hresp == ahbl_pkg::HRESP_ERROR && hready_resp) |->
	$past(hresp == ahbl_pkg::HRESP_ERROR && !hready_resp)
) else $error("ERROR response without its first stalled cycle");

endmodule

// ==== design/ahbl_sram.sv ====
// AHB-lite SRAM slave with zero wait states.
// Byte, halfword and word writes land on their own byte lanes.
// Word index wraps modulo SRAM_DEPTH.

`timescale 1ns/1ps

module ahbl_sram #(
	parameter int W_ADDR = 32,
	parameter int W_DATA = 32,
	parameter int SRAM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              hready,
	input  ahbl_pkg::htrans_t htrans,
	input  logic [W_ADDR-1:0] haddr,
	input  logic              hwrite,
	input  ahbl_pkg::hsize_t  hsize,
	input  logic [W_DATA-1:0] hwdata,
	output logic              hready_resp,
	output logic              hresp,
	output logic [W_DATA-1:0] hrdata
);

localparam int N_LANES = W_DATA / 8;
localparam int W_LANE = $clog2(N_LANES);
localparam int W_IDX = $clog2(SRAM_DEPTH);

logic [W_DATA-1:0]  mem [SRAM_DEPTH];
logic               aph_take;
logic [N_LANES-1:0] aph_lanes;
logic               dph_write;
logic [W_IDX-1:0]   dph_idx;
logic [N_LANES-1:0] dph_lanes;

assign aph_take = hready && htrans == ahbl_pkg::HTRANS_NONSEQ;

// Byte lanes from size and low address bits
always_comb begin
	case (hsize)
		ahbl_pkg::HSIZE_BYTE: aph_lanes = N_LANES'(1) << haddr[W_LANE-1:0];
		ahbl_pkg::HSIZE_HALF: aph_lanes = N_LANES'(3) << {haddr[W_LANE-1:1], 1'b0};
		// Word and anything wider
		default: aph_lanes = '1;
	endcase
end

// Data phase control
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dph_write <= 1'b0;
	end else if (hready) begin
		dph_write <= aph_take && hwrite;
	end
end

// Captured word index and lanes
always_ff @(posedge clk) begin
	if (aph_take) begin
		dph_idx <= haddr[W_IDX+1:2];
		dph_lanes <= aph_lanes;
	end
end

// Write in the single data-phase cycle
always_ff @(posedge clk) begin
	if (dph_write && hready) begin
		for (int b = 0; b < N_LANES; b++) begin
			if (dph_lanes[b]) begin
				mem[dph_idx][b*8 +: 8] <= hwdata[b*8 +: 8];
			end
		end
	end
end

// Read from the registered index
// Data valid in the same data-phase cycle
assign hrdata = mem[dph_idx];

// Never stalls and never errors
assign hready_resp = 1'b1;
assign hresp = ahbl_pkg::HRESP_OKAY;

endmodule

// ==== design/ahbl_splitter.sv ====
// AHB-lite 1:N address splitter.
// Decodes each address phase against ADDR_MAP and ADDR_MASK and gates HTRANS
// per port. A registered data-phase select muxes responses back to the master.
// At the top of a fabric, tie hready to hready_resp.

`timescale 1ns/1ps

module ahbl_splitter #(
	parameter int N_PORTS = 2,
	parameter int W_ADDR = 32,
	parameter int W_DATA = 32,
	parameter logic [N_PORTS*W_ADDR-1:0] ADDR_MAP = {32'h4000_0000, 32'h2000_0000},
	parameter logic [N_PORTS*W_ADDR-1:0] ADDR_MASK = {32'hf000_0000, 32'hf000_0000}
) (
	input  logic                                clk,
	input  logic                                rst_n,

	// Slave port towards the master
	input  logic                                hready,
	output logic                                hready_resp,
	output logic                                hresp,
	input  logic [W_ADDR-1:0]                   haddr,
	input  logic                                hwrite,
	input  ahbl_pkg::htrans_t                   htrans,
	input  ahbl_pkg::hsize_t                    hsize,
	input  ahbl_pkg::hburst_t                   hburst,
	input  ahbl_pkg::hprot_t                    hprot,
	input  logic                                hmastlock,
	input  logic [W_DATA-1:0]                   hwdata,
	output logic [W_DATA-1:0]                   hrdata,

	// Master ports towards the slaves
	output logic [N_PORTS-1:0]                  m_hready,
	input  logic [N_PORTS-1:0]                  m_hready_resp,
	input  logic [N_PORTS-1:0]                  m_hresp,
	output logic [N_PORTS-1:0][W_ADDR-1:0]      m_haddr,
	output logic [N_PORTS-1:0]                  m_hwrite,
	output ahbl_pkg::htrans_t [N_PORTS-1:0]     m_htrans,
	output ahbl_pkg::hsize_t [N_PORTS-1:0]      m_hsize,
	output ahbl_pkg::hburst_t [N_PORTS-1:0]     m_hburst,
	output ahbl_pkg::hprot_t [N_PORTS-1:0]      m_hprot,
	output logic [N_PORTS-1:0]                  m_hmastlock,
	output logic [N_PORTS-1:0][W_DATA-1:0]      m_hwdata,
	input  logic [N_PORTS-1:0][W_DATA-1:0]      m_hrdata
);

logic [N_PORTS-1:0] sel_a;
logic [N_PORTS-1:0] sel_d;
logic [N_PORTS-1:0] sel_resp;
logic               ready_muxed;

// Address decode
// An idle cycle selects nothing
always_comb begin
	sel_a = '0;
	if (htrans != ahbl_pkg::HTRANS_IDLE) begin
		for (int i = 0; i < N_PORTS; i++) begin
			sel_a[i] = ~|((haddr ^ ADDR_MAP[i*W_ADDR +: W_ADDR]) & ADDR_MASK[i*W_ADDR +: W_ADDR]);
		end
	end
end

// Address phase fans out unchanged
assign m_haddr     = {N_PORTS{haddr}};
assign m_hwrite    = {N_PORTS{hwrite}};
assign m_hsize     = {N_PORTS{hsize}};
assign m_hburst    = {N_PORTS{hburst}};
assign m_hprot     = {N_PORTS{hprot}};
assign m_hmastlock = {N_PORTS{hmastlock}};

// HTRANS is the only qualifier
// Unselected ports see IDLE
always_comb begin
	for (int i = 0; i < N_PORTS; i++) begin
		m_htrans[i] = sel_a[i] ? htrans : ahbl_pkg::HTRANS_IDLE;
	end
end

// Data phase select follows each accepted address phase
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		sel_d <= '0;
	end else if (hready) begin
		sel_d <= sel_a;
	end
end

assign m_hwdata = {N_PORTS{hwdata}};
assign m_hready = {N_PORTS{hready}};

// Open data phase owns the response
// Otherwise the slave being addressed reports its ready
assign sel_resp = (|sel_d) ? sel_d : sel_a;

bitmap_mux #(.N_INPUTS(N_PORTS), .W_INPUT(W_DATA)) hrdata_mux (
	.clk(clk), .rst_n(rst_n), .in(m_hrdata), .sel(sel_d), .out(hrdata)
);

bitmap_mux #(.N_INPUTS(N_PORTS), .W_INPUT(1)) hready_mux (
	.clk(clk), .rst_n(rst_n), .in(m_hready_resp), .sel(sel_resp), .out(ready_muxed)
);

bitmap_mux #(.N_INPUTS(N_PORTS), .W_INPUT(1)) hresp_mux (
	.clk(clk), .rst_n(rst_n), .in(m_hresp), .sel(sel_resp), .out(hresp)
);

// Zero-wait OKAY for idle with nothing in flight
assign hready_resp = ready_muxed | (htrans == ahbl_pkg::HTRANS_IDLE && !(|sel_d));

// No default slave here
// Every active address must hit exactly one port
nonseq_decodes: assert property (
	@(posedge clk) disable iff (!rst_n)
	htrans == ahbl_pkg::HTRANS_NONSEQ |-> $onehot(sel_a)
) else $error("active transfer matches no single splitter port");

// Stalled data phase must keep its slave until the stall ends
dph_sel_held: assert property (
	@(posedge clk) disable iff (!rst_n)
	(!hready_resp && |sel_d) |=> |sel_d
) else $error("data-phase select cleared during a wait state");

endmodule

// ==== design/bitmap_mux.sv ====
// One-hot AND-OR multiplexer.
// Used by the splitter to steer slave read data and responses back to the master.

`timescale 1ns/1ps

module bitmap_mux #(
	parameter int N_INPUTS = 2,
	parameter int W_INPUT = 32
) (
	// Clock and reset only feed the select check
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [N_INPUTS*W_INPUT-1:0] in,
	input  logic [N_INPUTS-1:0]         sel,
	output logic [W_INPUT-1:0]          out
);

always_comb begin
	out = '0;
	for (int i = 0; i < N_INPUTS; i++) begin
		// Mask each input with its select bit and merge
		out = out | (in[i*W_INPUT +: W_INPUT] & {W_INPUT{sel[i]}});
	end
end

// Overlapping selects would merge two slaves onto one bus
sel_onehot0: assert property (
	@(posedge clk) disable iff (!rst_n)
	$onehot0(sel)
) else $error("bitmap_mux select has more than one bit set");

endmodule

// ==== design/ahbl_pkg.sv ====
// Shared AHB-lite field types, transfer codes and register block constants.
// Modules and testbench refer to these by scoped names such as ahbl_pkg::HTRANS_NONSEQ.

package ahbl_pkg;

// Bus field widths
typedef logic [1:0] htrans_t;
typedef logic [2:0] hsize_t;
typedef logic [2:0] hburst_t;
typedef logic [3:0] hprot_t;

// Word offset inside the register block
typedef logic [1:0] regs_offset_t;

// Transfer types
// Only single transfers are issued on this fabric
localparam htrans_t HTRANS_IDLE   = 2'b00;
localparam htrans_t HTRANS_NONSEQ = 2'b10;

// Transfer sizes
localparam hsize_t HSIZE_BYTE = 3'b000;
localparam hsize_t HSIZE_HALF = 3'b001;
localparam hsize_t HSIZE_WORD = 3'b010;

// Slave response codes
localparam logic HRESP_OKAY  = 1'b0;
localparam logic HRESP_ERROR = 1'b1;

// Register block layout
// ID at offset 0, scratch registers fill offsets 1 to 3
localparam logic [31:0]  REGS_ID_VALUE  = 32'ha4b1_0001;
localparam regs_offset_t REGS_ID_OFFSET = 2'd0;
localparam int           REGS_N_SCRATCH = 3;

endpackage
